// File: all.f
source/vehicle_pkg.sv
source/traction_model.sv
source/speed_integrator.sv
source/gear_selector.sv
source/rpm_model.sv
source/odometer.sv
source/vehicle_top.sv
tests/vehicle_props.sv
tests/vehicle_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the drivetrain testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module vehicle_tb -f all.f -o vehicle_sim
output=$(./obj_dir/vehicle_sim)
echo "$output"
grep -qx "Verification passed" <<< "$output"

// File: tests/vehicle_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vehicle_tb;
    import vehicle_pkg::*;

    localparam int CLK_PERIOD  = 40;
    // longest possible sum of speed ticks over all tests
    localparam int SPEED_TICKS = 640;

    logic               clk = 1'b0;
    logic               rst;
    logic               engine_on;
    logic               tick_1sec;
    logic               tick_speed;
    lever_t             lever;
    logic [ACCEL_W-1:0] accel;
    logic               brake_normal;
    logic               brake_hard;
    logic [SPEED_W-1:0] speed;
    logic [RPM_W-1:0]   rpm;
    logic [GEAR_W-1:0]  gear_num;
    logic               ess_trigger;
    logic [ODO_W-1:0]   odometer;

    // reference model state
    int          m_speed;
    int          m_gear;
    int          m_ess;
    int          m_cnt;
    int          m_jit;
    int          m_rpm;
    int          m_acc;
    int          m_odo;
    logic [31:0] lfsr_state = 32'h7146;
    bit          check_req = 1'b0;
    int          checks = 0;
    int          errors = 0;

    vehicle_top vehicle_top_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // random throttle
    // ====================
    // taps 32 22 2 1
    function automatic logic lfsr_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            v = {v[6:0], lfsr_bit()};
        end
        return v;
    endfunction

    // ====================
    // reference model
    // ====================
    function automatic int rpm_ref(int spd, int gear, int jit, lever_t lev, int acc);
        int eff;
        int v;
        eff = (acc > ACCEL_DEAD_ZONE) ? acc - ACCEL_DEAD_ZONE : 0;
        if (!engine_on) begin
            return 0;
        end
        if (lev == LEVER_PARK || lev == LEVER_NEUTRAL) begin
            v = IDLE_RPM + acc * RPM_IDLE_SLOPE + jit;
            // limiter still shows the jitter
            return (v > RPM_IDLE_MAX) ? RPM_IDLE_MAX + jit : v;
        end
        v = RPM_SLOPE[gear] * spd + RPM_OFFSET[gear];
        if (v < 0) begin
            v = IDLE_RPM;
        end
        v = v + eff * RPM_LOAD_GAIN + jit;
        return (v > RPM_DRIVE_MAX) ? RPM_DRIVE_MAX : v;
    endfunction

    function automatic int next_gear(lever_t lev, int eff, int spd, int gear);
        int g;
        if (lev != LEVER_DRIVE) begin
            return 1;
        end
        if (eff == 0) begin
            // one gear up for every glide speed passed
            g = 1;
            for (int i = 1; i <= 5; i++) begin
                if (spd >= GLIDE_SPEED[i]) g = i + 1;
            end
            return g;
        end
        if (gear > 1 && spd < DOWN_SPEED[gear]) return gear - 1;
        if (gear < GEAR_MAX && spd >= UP_SPEED[gear]) return gear + 1;
        return gear;
    endfunction

    // one speed tick applied to the model state
    function automatic void step_model(lever_t lev, int acc, logic bn, logic bh);
        int eff;
        int power;
        int drag;
        int band;
        int lim;
        int rpm_now;
        int old_speed;
        eff       = (acc > ACCEL_DEAD_ZONE) ? acc - ACCEL_DEAD_ZONE : 0;
        power     = 0;
        if (engine_on && lev == LEVER_DRIVE) power = eff;
        if (engine_on && lev == LEVER_REVERSE) power = eff / 2;
        drag      = m_speed + DRAG_BASE + ((m_speed >= DRAG_HIGH_SPEED) ? DRAG_HIGH_EXTRA : 0);
        band      = (m_speed > BRAKE_BAND_HIGH) ? 0 : ((m_speed > BRAKE_BAND_MID) ? 1 : 2);
        rpm_now   = rpm_ref(m_speed, m_gear, m_jit, lev, acc);
        old_speed = m_speed;
        m_ess     = 0;
        if (bh) begin
            m_ess   = (old_speed > ESS_SPEED) ? 1 : 0;
            m_speed = (m_speed > BRAKE_HARD_STEP[band]) ? m_speed - BRAKE_HARD_STEP[band] : 0;
        end else if (bn) begin
            m_speed = (m_speed > BRAKE_NORMAL_STEP[band]) ? m_speed - BRAKE_NORMAL_STEP[band] : 0;
        end else begin
            if (power > drag) begin
                m_cnt = 0;
                if (m_speed < SPEED_MAX && rpm_now < REDLINE_GATE &&
                    !(lev == LEVER_REVERSE && m_speed >= REVERSE_SPEED_MAX)) m_speed++;
            end else if (power < drag) begin
                lim = COAST_LIMIT[m_gear];
                if (m_gear == 5 && m_speed >= COAST_G5_SPEED) lim = COAST_G5_LIMIT;
                if (m_gear == 6 && m_speed >= COAST_G6_SPEED_MD) lim = COAST_G6_LIMIT_MD;
                if (m_gear == 6 && m_speed >= COAST_G6_SPEED_HI) lim = COAST_G6_LIMIT_HI;
                if (m_speed > 0 && m_cnt >= lim) begin
                    m_speed--;
                    m_cnt = 0;
                end else begin
                    m_cnt = (m_cnt + 1) % 32;
                end
            end else begin
                m_cnt = 0;
            end
            m_gear = next_gear(lev, eff, old_speed, m_gear);
        end
        m_jit = (m_jit + 1) % 4;
        m_rpm = rpm_ref(m_speed, m_gear, m_jit, lev, acc);
    endfunction

    // ====================
    // stimulus and checks
    // ====================
    function automatic void compare_value(string name, int exp, int act);
        assert (exp == act) else begin
            $display("MISMATCH %s expected %h got %h", name, exp, act);
            errors++;
        end
    endfunction

    // outputs are stable at the falling edge after an update
    always @(negedge clk) begin
        if (check_req) begin
            check_req = 1'b0;
            checks++;
            compare_value("speed", m_speed, int'(speed));
            compare_value("gear_num", m_gear, int'(gear_num));
            compare_value("ess_trigger", m_ess, int'(ess_trigger));
            compare_value("rpm", m_rpm, int'(rpm));
            compare_value("odometer", m_odo, int'(odometer));
        end
    end

    // inputs change with the strobe and hold for four cycles
    task automatic speed_tick(lever_t lev, logic [7:0] acc, logic bn, logic bh);
        repeat (3) @(posedge clk);
        lever        <= lev;
        accel        <= acc;
        brake_normal <= bn;
        brake_hard   <= bh;
        tick_speed   <= 1'b1;
        @(posedge clk);
        tick_speed <= 1'b0;
        step_model(lev, int'(acc), bn, bh);
        check_req = 1'b1;
    endtask

    task automatic second_tick();
        @(posedge clk);
        tick_1sec <= 1'b1;
        @(posedge clk);
        tick_1sec <= 1'b0;
        if (engine_on && m_speed > 0) begin
            // km counted from the millimetres held before this second
            if (m_acc >= MM_PER_KM) begin
                m_odo++;
                m_acc = m_acc + m_speed * MM_PER_KMH_SEC - MM_PER_KM;
            end else begin
                m_acc = m_acc + m_speed * MM_PER_KMH_SEC;
            end
        end
        check_req = 1'b1;
    endtask

    task automatic report_test(string name, int base_err);
        @(posedge clk);
        if (errors == base_err) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - base_err);
    endtask

    initial begin
        int base_err;
        int n;
        rst          <= 1'b1;
        engine_on    <= 1'b0;
        tick_1sec    <= 1'b0;
        tick_speed   <= 1'b0;
        lever        <= LEVER_PARK;
        accel        <= '0;
        brake_normal <= 1'b0;
        brake_hard   <= 1'b0;
        m_speed = 0;
        m_gear  = 1;
        m_ess   = 0;
        m_cnt   = 0;
        m_jit   = 0;
        m_rpm   = 0;
        m_acc   = 0;
        m_odo   = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        base_err = errors;
        check_req = 1'b1;
        report_test("reset", base_err);

        base_err = errors;
        engine_on <= 1'b1;
        repeat (40) speed_tick(LEVER_PARK, rand_byte(), 1'b0, 1'b0);
        report_test("park idle rpm", base_err);

        base_err = errors;
        repeat (300) speed_tick(LEVER_DRIVE, rand_byte(), 1'b0, 1'b0);
        report_test("drive random throttle", base_err);

        // stop first, then climb backwards against the cap
        base_err = errors;
        n = 0;
        while (m_speed > 0 && n < 100) begin
            speed_tick(LEVER_DRIVE, 8'd0, 1'b0, 1'b1);
            n++;
        end
        repeat (70) speed_tick(LEVER_REVERSE, 8'd255, 1'b0, 1'b0);
        @(negedge clk);
        compare_value("reverse speed", REVERSE_SPEED_MAX, int'(speed));
        compare_value("reverse gear_num", 1, int'(gear_num));
        report_test("reverse cap", base_err);

        base_err = errors;
        repeat (110) speed_tick(LEVER_DRIVE, 8'd255, 1'b0, 1'b0);
        repeat (10) speed_tick(LEVER_DRIVE, 8'd0, 1'b0, 1'b1);
        repeat (10) speed_tick(LEVER_DRIVE, 8'd0, 1'b1, 1'b0);
        report_test("hard and normal braking", base_err);

        // no speed ticks, speed holds
        base_err = errors;
        repeat (80) second_tick();
        report_test("odometer", base_err);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog sized from the tick budget plus reset and odometer time
    initial begin
        #(SPEED_TICKS * 4 * CLK_PERIOD + 400 * CLK_PERIOD);
        $display("timeout: tests did not complete in time");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/vehicle_props.sv
`timescale 1ns/1ps
`default_nettype none

module vehicle_props (
    input logic                            clk,
    input logic                            rst,
    input logic                            tick_speed,
    input logic                            brake_hard,
    input logic [vehicle_pkg::SPEED_W-1:0] speed,
    input logic [vehicle_pkg::GEAR_W-1:0]  gear_num,
    input logic [vehicle_pkg::RPM_W-1:0]   rpm,
    input logic                            ess_trigger
);
    import vehicle_pkg::*;

    // ====================
    // output ranges
    // ====================
    speed_cap: assert property (@(posedge clk) disable iff (rst)
        speed <= SPEED_W'(SPEED_MAX))
        else $error("speed above top speed");

    gear_range: assert property (@(posedge clk) disable iff (rst)
        gear_num >= GEAR_W'(1) && gear_num <= GEAR_W'(GEAR_MAX))
        else $error("gear_num outside 1 to 6");

    rpm_cap: assert property (@(posedge clk) disable iff (rst)
        rpm <= RPM_W'(RPM_DRIVE_MAX))
        else $error("rpm above drive limit");

    // emergency stop only comes from a hard brake tick
    ess_source: assert property (@(posedge clk) disable iff (rst)
        $rose(ess_trigger) |-> $past(tick_speed && brake_hard))
        else $error("ess_trigger rose without a hard brake tick");

endmodule

bind vehicle_top vehicle_props vehicle_props_i (
    .clk(clk), .rst(rst), .tick_speed(tick_speed), .brake_hard(brake_hard),
    .speed(speed), .gear_num(gear_num), .rpm(rpm), .ess_trigger(ess_trigger)
);

`default_nettype wire

// File: source/vehicle_top.sv
`timescale 1ns/1ps
`default_nettype none

module vehicle_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            engine_on,
    input  logic                            tick_1sec,
    input  logic                            tick_speed,
    input  vehicle_pkg::lever_t             lever,
    input  logic [vehicle_pkg::ACCEL_W-1:0] accel,
    input  logic                            brake_normal,
    input  logic                            brake_hard,
    output logic [vehicle_pkg::SPEED_W-1:0] speed,
    output logic [vehicle_pkg::RPM_W-1:0]   rpm,
    output logic [vehicle_pkg::GEAR_W-1:0]  gear_num,
    output logic                            ess_trigger,
    output logic [vehicle_pkg::ODO_W-1:0]   odometer
);
    import vehicle_pkg::*;

    logic [ACCEL_W-1:0] eff_accel;
    force_balance_t     balance;
    logic               coast_step;

    // pedal and lever to force balance
    traction_model traction_model_i (
        .accel(accel), .lever(lever), .engine_on(engine_on), .speed(speed),
        .eff_accel(eff_accel), .balance(balance)
    );

    // speed state, braking and emergency stop
    speed_integrator speed_integrator_i (
        .clk(clk), .rst(rst), .tick_speed(tick_speed),
        .brake_normal(brake_normal), .brake_hard(brake_hard),
        .lever(lever), .balance(balance), .gear_num(gear_num), .rpm(rpm),
        .speed(speed), .ess_trigger(ess_trigger), .coast_step(coast_step)
    );

    gear_selector gear_selector_i (
        .clk(clk), .rst(rst), .coast_step(coast_step), .lever(lever),
        .eff_accel(eff_accel), .speed(speed), .gear_num(gear_num)
    );

    // rpm feeds back into the redline gate
    rpm_model rpm_model_i (
        .clk(clk), .rst(rst), .tick_speed(tick_speed), .engine_on(engine_on),
        .lever(lever), .accel(accel), .eff_accel(eff_accel), .speed(speed),
        .gear_num(gear_num), .rpm(rpm)
    );

    odometer odometer_i (
        .clk(clk), .rst(rst), .tick_1sec(tick_1sec), .engine_on(engine_on),
        .speed(speed), .odometer(odometer)
    );

endmodule

`default_nettype wire

// File: source/odometer.sv
`timescale 1ns/1ps
`default_nettype none

module odometer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            tick_1sec,
    input  logic                            engine_on,
    input  logic [vehicle_pkg::SPEED_W-1:0] speed,
    output logic [vehicle_pkg::ODO_W-1:0]   odometer
);
    import vehicle_pkg::*;

    logic [ODO_W-1:0] mm_acc;
    logic [ODO_W-1:0] mm_step;

    // 1 km/h for one second is about 278 mm
    assign mm_step = ODO_W'(speed) * ODO_W'(MM_PER_KMH_SEC);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mm_acc   <= '0;
            odometer <= '0;
        end else if (tick_1sec && engine_on && speed != '0) begin
            // rollover checked on the value from before this second
            if (mm_acc >= ODO_W'(MM_PER_KM)) begin
                odometer <= odometer + 1'b1;
                mm_acc   <= mm_acc + mm_step - ODO_W'(MM_PER_KM);
            end else begin
                mm_acc   <= mm_acc + mm_step;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rpm_model.sv
`timescale 1ns/1ps
`default_nettype none

module rpm_model (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            tick_speed,
    input  logic                            engine_on,
    input  vehicle_pkg::lever_t             lever,
    input  logic [vehicle_pkg::ACCEL_W-1:0] accel,
    input  logic [vehicle_pkg::ACCEL_W-1:0] eff_accel,
    input  logic [vehicle_pkg::SPEED_W-1:0] speed,
    input  logic [vehicle_pkg::GEAR_W-1:0]  gear_num,
    output logic [vehicle_pkg::RPM_W-1:0]   rpm
);
    import vehicle_pkg::*;

    logic [1:0] jitter;
    int         idle_calc;
    int         base_rpm;
    int         drive_calc;

    // small wobble on the needle, like a running engine
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            jitter <= '0;
        end else if (tick_speed) begin
            jitter <= jitter + 1'b1;
        end
    end

    // ====================
    // idle, park and neutral
    // ====================
    // raw pedal here, so pedal noise shows on the gauge
    assign idle_calc = IDLE_RPM + int'(accel) * RPM_IDLE_SLOPE + int'(jitter);

    // ====================
    // driving, drive and reverse
    // ====================
    always_comb begin
        base_rpm = IDLE_RPM;
        if (gear_num >= GEAR_W'(1) && gear_num <= GEAR_W'(GEAR_MAX)) begin
            base_rpm = RPM_SLOPE[gear_num] * int'(speed) + RPM_OFFSET[gear_num];
        end
        // low speed in a high gear falls back to idle
        if (base_rpm < 0) begin
            base_rpm = IDLE_RPM;
        end
        // throttle load, converter slip
        drive_calc = base_rpm + int'(eff_accel) * RPM_LOAD_GAIN + int'(jitter);
    end

    always_comb begin
        if (!engine_on) begin
            rpm = '0;
        end else if (lever == LEVER_PARK || lever == LEVER_NEUTRAL) begin
            // rev limiter keeps the jitter
            if (idle_calc > RPM_IDLE_MAX) begin
                rpm = RPM_W'(RPM_IDLE_MAX + int'(jitter));
            end else begin
                rpm = RPM_W'(idle_calc);
            end
        end else if (drive_calc > RPM_DRIVE_MAX) begin
            rpm = RPM_W'(RPM_DRIVE_MAX);
        end else begin
            rpm = RPM_W'(drive_calc);
        end
    end

endmodule

`default_nettype wire

// File: source/gear_selector.sv
`timescale 1ns/1ps
`default_nettype none

module gear_selector (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            coast_step,
    input  vehicle_pkg::lever_t             lever,
    input  logic [vehicle_pkg::ACCEL_W-1:0] eff_accel,
    input  logic [vehicle_pkg::SPEED_W-1:0] speed,
    output logic [vehicle_pkg::GEAR_W-1:0]  gear_num
);
    import vehicle_pkg::*;

    logic [GEAR_W-1:0] glide_gear;
    logic [GEAR_W-1:0] shift_gear;

    // ====================
    // gliding, gear straight from speed
    // ====================
    // lowest gear whose limit is still above speed wins
    always_comb begin
        glide_gear = GEAR_W'(GEAR_MAX);
        for (int i = GEAR_MAX - 1; i >= 1; i--) begin
            if (speed < SPEED_W'(GLIDE_SPEED[i])) begin
                glide_gear = GEAR_W'(i);
            end
        end
    end

    // ====================
    // under load, one gear at a time
    // ====================
    // separate up and down points avoid hunting between gears
    always_comb begin
        shift_gear = gear_num;
        if (gear_num == '0 || gear_num > GEAR_W'(GEAR_MAX)) begin
            shift_gear = GEAR_W'(1);
        end else if (gear_num > GEAR_W'(1) &&
                     speed < SPEED_W'(DOWN_SPEED[gear_num])) begin
            shift_gear = gear_num - 1'b1;
        end else if (gear_num < GEAR_W'(GEAR_MAX) &&
                     speed >= SPEED_W'(UP_SPEED[gear_num])) begin
            shift_gear = gear_num + 1'b1;
        end
    end

    // decision uses the speed from before the current tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gear_num <= GEAR_W'(1);
        end else if (coast_step) begin
            if (lever != LEVER_DRIVE) begin
                // park, reverse and neutral sit in first
                gear_num <= GEAR_W'(1);
            end else if (eff_accel == '0) begin
                gear_num <= glide_gear;
            end else begin
                gear_num <= shift_gear;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/speed_integrator.sv
`timescale 1ns/1ps
`default_nettype none

module speed_integrator (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            tick_speed,
    input  logic                            brake_normal,
    input  logic                            brake_hard,
    input  vehicle_pkg::lever_t             lever,
    input  vehicle_pkg::force_balance_t     balance,
    input  logic [vehicle_pkg::GEAR_W-1:0]  gear_num,
    input  logic [vehicle_pkg::RPM_W-1:0]   rpm,
    output logic [vehicle_pkg::SPEED_W-1:0] speed,
    output logic                            ess_trigger,
    output logic                            coast_step
);
    import vehicle_pkg::*;

    logic [1:0]         band;
    logic [SPEED_W-1:0] brake_step;
    logic [SPEED_W-1:0] braked_speed;
    logic [4:0]         coast_limit;
    logic [4:0]         coast_cnt;
    logic               accel_ok;

    // gear logic only runs on ticks without braking
    assign coast_step = tick_speed && !brake_normal && !brake_hard;

    // ====================
    // braking
    // ====================
    // tyres slip at high speed, so the step shrinks
    always_comb begin
        if (speed > SPEED_W'(BRAKE_BAND_HIGH)) begin
            band = 2'd0;
        end else if (speed > SPEED_W'(BRAKE_BAND_MID)) begin
            band = 2'd1;
        end else begin
            band = 2'd2;
        end
    end

    assign brake_step   = brake_hard ? SPEED_W'(BRAKE_HARD_STEP[band]) :
                                       SPEED_W'(BRAKE_NORMAL_STEP[band]);
    // floor at standstill
    assign braked_speed = (speed >= brake_step) ? speed - brake_step : '0;

    // ====================
    // acceleration and coasting
    // ====================
    // top speed, redline and the reverse cap all block acceleration
    assign accel_ok = (speed < SPEED_W'(SPEED_MAX)) &&
                      (rpm < RPM_W'(REDLINE_GATE)) &&
                      !(lever == LEVER_REVERSE && speed >= SPEED_W'(REVERSE_SPEED_MAX));

    // ticks per km/h lost while coasting
    always_comb begin
        // unknown gear loses speed every tick
        coast_limit = 5'd0;
        if (gear_num >= GEAR_W'(1) && gear_num <= GEAR_W'(GEAR_MAX)) begin
            coast_limit = 5'(COAST_LIMIT[gear_num]);
        end
        if (gear_num == GEAR_W'(5) && speed >= SPEED_W'(COAST_G5_SPEED)) begin
            coast_limit = 5'(COAST_G5_LIMIT);
        end
        if (gear_num == GEAR_W'(6)) begin
            if (speed >= SPEED_W'(COAST_G6_SPEED_HI)) begin
                coast_limit = 5'(COAST_G6_LIMIT_HI);
            end else if (speed >= SPEED_W'(COAST_G6_SPEED_MD)) begin
                coast_limit = 5'(COAST_G6_LIMIT_MD);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            speed       <= '0;
            ess_trigger <= 1'b0;
            coast_cnt   <= '0;
        end else if (tick_speed) begin
            if (brake_hard) begin
                speed       <= braked_speed;
                // emergency stop lamp judged on the speed before braking
                ess_trigger <= (speed > SPEED_W'(ESS_SPEED));
            end else if (brake_normal) begin
                speed       <= braked_speed;
                ess_trigger <= 1'b0;
            end else begin
                ess_trigger <= 1'b0;
                case (balance)
                    BAL_PUSH: begin
                        coast_cnt <= '0;
                        if (accel_ok) begin
                            speed <= speed + 1'b1;
                        end
                    end
                    BAL_DRAG: begin
                        // counter keeps running at standstill
                        if (speed != '0 && coast_cnt >= coast_limit) begin
                            speed     <= speed - 1'b1;
                            coast_cnt <= '0;
                        end else begin
                            coast_cnt <= coast_cnt + 1'b1;
                        end
                    end
                    default: coast_cnt <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/traction_model.sv
`timescale 1ns/1ps
`default_nettype none

module traction_model (
    input  logic [vehicle_pkg::ACCEL_W-1:0] accel,
    input  vehicle_pkg::lever_t             lever,
    input  logic                            engine_on,
    input  logic [vehicle_pkg::SPEED_W-1:0] speed,
    output logic [vehicle_pkg::ACCEL_W-1:0] eff_accel,
    output vehicle_pkg::force_balance_t     balance
);
    import vehicle_pkg::*;

    logic [FORCE_W-1:0] power;
    logic [FORCE_W-1:0] drag;

    // dead zone keeps sensor noise from creeping the car forward
    assign eff_accel = (accel > ACCEL_W'(ACCEL_DEAD_ZONE)) ?
                       accel - ACCEL_W'(ACCEL_DEAD_ZONE) : '0;

    // engine power reaches the wheels only in drive or reverse
    always_comb begin
        power = '0;
        if (engine_on && lever == LEVER_DRIVE) begin
            power = FORCE_W'(eff_accel);
        end else if (engine_on && lever == LEVER_REVERSE) begin
            // half power going backwards
            power = FORCE_W'(eff_accel >> 1);
        end
    end

    // rolling drag grows with speed, steep jump near top speed
    always_comb begin
        drag = FORCE_W'(speed) + FORCE_W'(DRAG_BASE);
        if (speed >= SPEED_W'(DRAG_HIGH_SPEED)) begin
            drag = drag + FORCE_W'(DRAG_HIGH_EXTRA);
        end
    end

    always_comb begin
        if (power > drag) begin
            balance = BAL_PUSH;
        end else if (power < drag) begin
            balance = BAL_DRAG;
        end else begin
            balance = BAL_EVEN;
        end
    end

endmodule

`default_nettype wire

// File: source/vehicle_pkg.sv
`default_nettype none

package vehicle_pkg;

    // ====================
    // shift lever and force balance
    // ====================
    typedef enum logic [3:0] {
        LEVER_PARK    = 4'd3,
        LEVER_REVERSE = 4'd6,
        LEVER_NEUTRAL = 4'd9,
        LEVER_DRIVE   = 4'd12
    } lever_t;

    // result of traction against drag
    typedef enum logic [1:0] {
        BAL_PUSH,
        BAL_DRAG,
        BAL_EVEN
    } force_balance_t;

    // datapath widths
    localparam int SPEED_W = 8;
    localparam int RPM_W   = 14;
    localparam int ACCEL_W = 8;
    localparam int GEAR_W  = 3;
    localparam int ODO_W   = 32;
    localparam int FORCE_W = 10;

    // ====================
    // physics constants
    // ====================
    localparam int IDLE_RPM          = 800;
    localparam int ACCEL_DEAD_ZONE   = 5;
    localparam int DRAG_BASE         = 5;
    localparam int DRAG_HIGH_SPEED   = 180;
    localparam int DRAG_HIGH_EXTRA   = 100;
    localparam int SPEED_MAX         = 250;
    localparam int REDLINE_GATE      = 7900;
    localparam int RPM_DRIVE_MAX     = 8000;
    localparam int RPM_IDLE_MAX      = 4000;
    localparam int RPM_IDLE_SLOPE    = 20;
    localparam int RPM_LOAD_GAIN     = 2;
    localparam int REVERSE_SPEED_MAX = 50;
    localparam int ESS_SPEED         = 50;
    localparam int BRAKE_BAND_HIGH   = 150;
    localparam int BRAKE_BAND_MID    = 80;
    localparam int MM_PER_KMH_SEC    = 278;
    localparam int MM_PER_KM         = 1_000_000;
    localparam int GEAR_MAX          = 6;

    // ====================
    // tables
    // ====================
    // brake steps, band 0 is above BRAKE_BAND_HIGH
    localparam int BRAKE_NORMAL_STEP [0:2] = '{1, 2, 3};
    localparam int BRAKE_HARD_STEP   [0:2] = '{2, 4, 8};

    // coast ticks per one km/h lost, by gear
    localparam int COAST_LIMIT [1:6] = '{1, 3, 6, 10, 15, 20};
    // faster coasting in the top gears, air drag dominates there
    localparam int COAST_G5_SPEED    = 120;
    localparam int COAST_G5_LIMIT    = 8;
    localparam int COAST_G6_SPEED_HI = 170;
    localparam int COAST_G6_LIMIT_HI = 2;
    localparam int COAST_G6_SPEED_MD = 140;
    localparam int COAST_G6_LIMIT_MD = 5;

    // gliding gear limits, gear i holds below GLIDE_SPEED[i]
    localparam int GLIDE_SPEED [1:5] = '{20, 50, 75, 100, 125};
    // hysteresis, up from gear i and down from gear i
    localparam int UP_SPEED    [1:5] = '{27, 56, 86, 117, 146};
    localparam int DOWN_SPEED  [2:6] = '{21, 51, 77, 101, 128};

    // rpm = slope * speed + offset per gear
    localparam int RPM_SLOPE  [1:6] = '{60, 35, 35, 30, 27, 27};
    localparam int RPM_OFFSET [1:6] = '{800, 450, -600, -1100, -1540, -2250};

endpackage

`default_nettype wire
